// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // data path and address width
    localparam int unsigned xlen = 32;

    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned imm_w      = 16; // also the lui shift distance
    localparam int unsigned shamt_w    = 5;
    localparam int unsigned target_w   = 26;

    // function selected by decode for the ALU
    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_addu = 5'd1,
        alu_sub  = 5'd2,
        alu_subu = 5'd3,
        alu_and  = 5'd4,
        alu_or   = 5'd5,
        alu_xor  = 5'd6,
        alu_nor  = 5'd7,
        alu_sll  = 5'd8,
        alu_srl  = 5'd9,
        alu_sra  = 5'd10,
        alu_slt  = 5'd11,
        alu_sltu = 5'd12,
        alu_lui  = 5'd13
    } alu_op_e;

    // the zero-compare forms see rt as zero from decode
    typedef enum logic [2:0] {
        br_bltz = 3'd0,
        br_bgez = 3'd1,
        br_beq  = 3'd2,
        br_bne  = 3'd3,
        br_blez = 3'd4,
        br_bgtz = 3'd5
    } branch_op_e;

endpackage

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // one decoded instruction as it leaves decode
    typedef struct packed {
        logic                      valid;
        logic [xlen-1:0]           pc;
        logic                      rs_used;
        logic [reg_addr_w-1:0]     rs_addr;
        logic [xlen-1:0]           rs_data;
        logic                      rt_used;
        logic [reg_addr_w-1:0]     rt_addr;
        logic [xlen-1:0]           rt_data;
        logic                      rd_write;
        logic [reg_addr_w-1:0]     rd_addr;
        logic                      shamt_en;
        logic [shamt_w-1:0]        shamt;
        logic                      imm_en;
        logic [imm_w-1:0]          imm;
        logic                      target_en;
        logic [target_w-1:0]       target;
        logic                      alu_en;
        alu_op_e                   alu_op;
        logic                      branch;
        branch_op_e                branch_op;
        logic                      jump;
        logic                      link;
        logic                      load;
        logic                      store;
    } id_ex_t;

    typedef struct packed {
        logic                  rd_write;
        logic [reg_addr_w-1:0] rd_addr;
        logic [xlen-1:0]       rd_data;
    } wb_bypass_t;

    typedef struct packed {
        logic                  [xlen-1:0] pc;
        logic                             alu_en;
        logic                  [xlen-1:0] result;
        logic                  [xlen-1:0] store_data; // forwarded rt value
        logic                             rd_write;
        logic            [reg_addr_w-1:0] rd_addr;
        logic                             load;
        logic                             store;
    } ex_mem_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef enum logic [1:0] {
        from_id = 2'd0,
        from_ex = 2'd1,
        from_wb = 2'd2
    } fwd_src_e;

endpackage

`default_nettype wire

// File: hw/operand_select.sv
`default_nettype none

module operand_select
    import isa_pkg::*, pipe_pkg::*;
(
    input  var id_ex_t          id,
    input  var wb_bypass_t      wb,
    input  var ex_mem_t         ex_prev,
    output logic [xlen-1:0]     op_a,
    output logic [xlen-1:0]     op_b,
    output logic [xlen-1:0]     rt_fwd,
    output logic [xlen-1:0]     imm_ext
);

    fwd_src_e rs_sel;
    fwd_src_e rt_sel;
    logic     sign_ext;

    // the younger ex result has priority over writeback
    function automatic fwd_src_e pick_source(
        input logic                  used,
        input logic [reg_addr_w-1:0] addr,
        input ex_mem_t               ex,
        input wb_bypass_t            w
    );
        fwd_src_e src;
        src = from_id;
        if (used && ex.rd_write && (ex.rd_addr == addr)) begin
            src = from_ex;
        end else if (used && w.rd_write && (w.rd_addr == addr)) begin
            src = from_wb;
        end
        return src;
    endfunction

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_src_e        sel,
        input logic [xlen-1:0] reg_data,
        input logic [xlen-1:0] ex_data,
        input logic [xlen-1:0] wb_data
    );
        case (sel)
            from_ex: return ex_data;
            from_wb: return wb_data;
            default: return reg_data;
        endcase
    endfunction

    assign rs_sel = pick_source(id.rs_used, id.rs_addr, ex_prev, wb);
    assign rt_sel = pick_source(id.rt_used, id.rt_addr, ex_prev, wb);

    assign op_a   = fwd_mux(rs_sel, id.rs_data, ex_prev.result, wb.rd_data);
    assign rt_fwd = fwd_mux(rt_sel, id.rt_data, ex_prev.result, wb.rd_data);

    // address offsets and signed arithmetic take a sign-extended immediate
    assign sign_ext = id.load || id.store || id.branch
        || (id.alu_en && (id.alu_op inside {alu_add, alu_addu, alu_sub, alu_subu, alu_slt}));

    always_comb begin
        if (id.imm_en) begin
            if (sign_ext) begin
                imm_ext = {{(xlen - imm_w){id.imm[imm_w-1]}}, id.imm};
            end else begin
                imm_ext = {{(xlen - imm_w){1'b0}}, id.imm};
            end
        end else if (id.shamt_en) begin
            imm_ext = {{(xlen - shamt_w){1'b0}}, id.shamt};
        end else begin
            imm_ext = '0;
        end
    end

    // branches always compare two registers
    assign op_b = id.branch ? rt_fwd : ((id.imm_en || id.shamt_en) ? imm_ext : rt_fwd);

endmodule

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

module alu
    import isa_pkg::*, pipe_pkg::*;
(
    input  var id_ex_t          id,
    input  var logic [xlen-1:0] a,
    input  var logic [xlen-1:0] b,
    output logic [xlen-1:0]     result
);

    logic [shamt_w-1:0] sh;
    logic               lt_signed;
    logic               lt_unsigned;

    assign sh          = b[shamt_w-1:0]; // only the low bits count as a shift
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        result = '0;
        if (id.load || id.store) begin
            result = a + b; // effective address
        end else if (id.alu_en) begin
            case (id.alu_op)
                alu_add: begin
                    result = a + b;
                end
                alu_addu: begin
                    // a linking jump writes the return address past the delay slot
                    if (id.link) begin
                        result = id.pc + xlen'(8);
                    end else begin
                        result = a + b;
                    end
                end
                alu_sub, alu_subu: begin
                    result = a - b;
                end
                alu_and: begin
                    result = a & b;
                end
                alu_or: begin
                    result = a | b;
                end
                alu_xor: begin
                    result = a ^ b;
                end
                alu_nor: begin
                    result = ~(a | b);
                end
                alu_sll: begin
                    result = a << sh;
                end
                alu_srl: begin
                    result = a >> sh;
                end
                alu_sra: begin
                    result = $unsigned($signed(a) >>> sh);
                end
                alu_slt: begin
                    result = {{(xlen - 1){1'b0}}, lt_signed};
                end
                alu_sltu: begin
                    result = {{(xlen - 1){1'b0}}, lt_unsigned};
                end
                alu_lui: begin
                    result = b << imm_w;
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  var id_ex_t          id,
    input  var logic [xlen-1:0] rs_val,
    input  var logic [xlen-1:0] rt_val,
    input  var logic [xlen-1:0] imm_ext,
    output redirect_t           redirect,
    output logic                rd_write
);

    logic cond;

    always_comb begin
        case (id.branch_op)
            br_bltz: cond = $signed(rs_val) < $signed(rt_val);
            br_bgez: cond = $signed(rs_val) >= $signed(rt_val);
            br_beq:  cond = rs_val == rt_val;
            br_bne:  cond = rs_val != rt_val;
            br_blez: cond = $signed(rs_val) <= $signed(rt_val);
            br_bgtz: cond = $signed(rs_val) > $signed(rt_val);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect.taken  = id.valid && (id.jump || (id.branch && cond));
        redirect.target = '0;
        rd_write        = id.rd_write;
        if (id.valid && (id.branch || id.jump)) begin
            if (id.target_en) begin
                // pseudo-direct jump within the low segment
                redirect.target = {{(xlen - target_w - 2){1'b0}}, id.target, 2'b00};
            end else if (id.imm_en) begin
                redirect.target = id.pc + xlen'(4) + (imm_ext << 2);
            end else if (id.rs_used) begin
                redirect.target = rs_val;
            end
            rd_write = id.link && redirect.taken; // an untaken link branch writes nothing
        end
    end

endmodule

`default_nettype wire

// File: hw/ex_mem_register.sv
`default_nettype none

module ex_mem_register
    import pipe_pkg::*;
(
    input  var logic    clk,
    input  var logic    nrst,
    input  var ex_mem_t d,
    output ex_mem_t     q
);

    // whole bundle clears so the memory stage sees a bubble out of reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none

module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  var logic       clk,
    input  var logic       nrst,
    input  var id_ex_t     id,
    input  var wb_bypass_t wb,
    output ex_mem_t        ex_mem,
    output redirect_t      redirect
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] rt_fwd;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] alu_result;
    logic            rd_write;
    logic            live;
    ex_mem_t         ex_next;

    operand_select i_operand_select (
        .id      (id),
        .wb      (wb),
        .ex_prev (ex_mem), // registered result closes the ex forwarding path
        .op_a    (op_a),
        .op_b    (op_b),
        .rt_fwd  (rt_fwd),
        .imm_ext (imm_ext)
    );

    alu i_alu (
        .id     (id),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    branch_unit i_branch_unit (
        .id       (id),
        .rs_val   (op_a),
        .rt_val   (rt_fwd),
        .imm_ext  (imm_ext),
        .redirect (redirect),
        .rd_write (rd_write)
    );

    // an empty slot becomes an all-zero bubble
    assign live = id.valid
        && (id.alu_en || id.load || id.store || id.branch || id.jump || id.rd_write);

    always_comb begin
        ex_next = '0;
        if (live) begin
            ex_next.pc         = id.pc;
            ex_next.alu_en     = id.alu_en;
            ex_next.result     = alu_result;
            ex_next.store_data = rt_fwd;
            ex_next.rd_write   = rd_write;
            ex_next.rd_addr    = id.rd_addr;
            ex_next.load       = id.load;
            ex_next.store      = id.store;
        end
    end

    ex_mem_register i_ex_mem_register (
        .clk  (clk),
        .nrst (nrst),
        .d    (ex_next),
        .q    (ex_mem)
    );

endmodule

`default_nettype wire

// File: verification/execute_stage_assertions.sv
`default_nettype none

module execute_stage_assertions
    import pipe_pkg::*;
(
    input var logic      clk,
    input var logic      nrst,
    input var id_ex_t    id,
    input var ex_mem_t   ex_mem,
    input var redirect_t redirect
);

    timeunit 1ns;
    timeprecision 1ps;

    // the memory stage must see a bubble throughout reset
    reset_clears: assert property (@(posedge clk) !nrst |-> (ex_mem == '0))
        else $error("ex_mem not cleared during reset");

    redirect_needs_control: assert property (@(posedge clk) disable iff (!nrst)
        redirect.taken |-> (id.branch || id.jump))
        else $error("redirect taken without a branch or jump");

    untaken_link_no_write: assert property (@(posedge clk) disable iff (!nrst)
        (id.valid && id.branch && id.link && !redirect.taken) |=> !ex_mem.rd_write)
        else $error("untaken linking branch set rd write");

endmodule

bind execute_stage execute_stage_assertions i_execute_stage_assertions (
    .clk      (clk),
    .nrst     (nrst),
    .id       (id),
    .ex_mem   (ex_mem),
    .redirect (redirect)
);

`default_nettype wire

// File: verification/execute_stage_vectors.svh
`ifndef EXECUTE_STAGE_VECTORS_SVH
`define EXECUTE_STAGE_VECTORS_SVH

// the columns are the decoded instruction, the writeback bundle and the data source flag
// a flag of 1 takes register data from the LCG and 0 keeps it fixed
// expected redirect and ex_mem are filled in afterwards by the reference model
task automatic build_rows();
    push_row(mk_rr(alu_add, 5'd1, 5'd2, 5'd10), '0, 1'b1);
    push_row(mk_rr(alu_addu, 5'd1, 5'd2, 5'd11), '0, 1'b1);
    push_row(mk_rr(alu_sub, 5'd3, 5'd4, 5'd12), '0, 1'b1);
    push_row(mk_rr(alu_subu, 5'd3, 5'd4, 5'd13), '0, 1'b1);
    push_row(mk_rr(alu_and, 5'd5, 5'd6, 5'd14), '0, 1'b1);
    push_row(mk_rr(alu_or, 5'd5, 5'd6, 5'd15), '0, 1'b1);
    push_row(mk_rr(alu_xor, 5'd5, 5'd6, 5'd16), '0, 1'b1);
    push_row(mk_rr(alu_nor, 5'd5, 5'd6, 5'd17), '0, 1'b1);
    push_row(mk_rr(alu_slt, 5'd1, 5'd3, 5'd18), '0, 1'b1);
    push_row(mk_rr(alu_sltu, 5'd1, 5'd3, 5'd19), '0, 1'b1);
    push_row(mk_ri(alu_add, 5'd1, 5'd10, 16'hfff0), '0, 1'b1);
    push_row(mk_ri(alu_addu, 5'd2, 5'd11, 16'h8001), '0, 1'b1);
    push_row(mk_ri(alu_and, 5'd3, 5'd12, 16'hf0f0), '0, 1'b1);
    push_row(mk_ri(alu_or, 5'd4, 5'd13, 16'h8000), '0, 1'b1);
    push_row(mk_ri(alu_xor, 5'd5, 5'd14, 16'hffff), '0, 1'b1);
    // a zero rs tells a sign-extended immediate from a zero-extended one
    push_row(mk_ri(alu_slt, 5'd6, 5'd15, 16'h8000), '0, 1'b0);
    push_row(mk_ri(alu_sltu, 5'd7, 5'd16, 16'h8000), '0, 1'b1);
    push_row(mk_ri(alu_lui, 5'd0, 5'd17, 16'hbeef), '0, 1'b1);
    push_row(mk_sh(alu_sll, 5'd1, 5'd18, 5'd7), '0, 1'b1);
    push_row(mk_sh(alu_srl, 5'd2, 5'd19, 5'd31), '0, 1'b1);
    push_row(mk_sh(alu_sra, 5'd3, 5'd20, 5'd4), '0, 1'b1);
    push_row(mk_rr(alu_sra, 5'd3, 5'd4, 5'd21), '0, 1'b1);
    push_row(mk_rr(alu_sll, 5'd3, 5'd4, 5'd26), '0, 1'b1);
    push_row(mk_rr(alu_srl, 5'd3, 5'd4, 5'd27), '0, 1'b1);
    push_row(mk_mem(1'b1, 5'd1, 5'd22, 16'hfffc), '0, 1'b1);
    push_row(mk_mem(1'b0, 5'd2, 5'd23, 16'h0010), '0, 1'b1);
    // dependent chains, writeback match and ex over writeback
    push_row(mk_rr(alu_add, 5'd1, 5'd2, 5'd5), '0, 1'b1);
    push_row(mk_rr(alu_sub, 5'd5, 5'd5, 5'd6), '0, 1'b1);
    push_row(mk_rr(alu_or, 5'd7, 5'd8, 5'd9), wb_write(5'd7, 32'h1234_5678), 1'b1);
    push_row(mk_rr(alu_xor, 5'd9, 5'd9, 5'd1), wb_write(5'd9, 32'hdead_beef), 1'b1);
    push_row(mk_mem(1'b0, 5'd2, 5'd1, 16'h0004), '0, 1'b1);
    push_row(without_valid(mk_rr(alu_add, 5'd1, 5'd2, 5'd3)), '0, 1'b1);
    push_row(mk_empty(), '0, 1'b1);
    push_row(mk_br(br_beq, 32'd5, 32'd5, 1'b1, 16'h0010), '0, 1'b0);
    push_row(mk_br(br_beq, 32'd5, 32'd6, 1'b1, 16'h0010), '0, 1'b0);
    push_row(mk_br(br_bne, 32'd7, 32'd9, 1'b1, 16'hfff8), '0, 1'b0);
    push_row(mk_br(br_bne, 32'd7, 32'd7, 1'b1, 16'hfff8), '0, 1'b0);
    push_row(mk_br(br_bltz, 32'hffff_ffff, 32'd0, 1'b0, 16'h0020), '0, 1'b0);
    push_row(mk_br(br_bltz, 32'd1, 32'd0, 1'b0, 16'h0020), '0, 1'b0);
    push_row(mk_br(br_bgez, 32'd0, 32'd0, 1'b0, 16'hff00), '0, 1'b0);
    push_row(mk_br(br_bgez, 32'h8000_0000, 32'd0, 1'b0, 16'hff00), '0, 1'b0);
    push_row(mk_br(br_blez, 32'd0, 32'd0, 1'b0, 16'h0004), '0, 1'b0);
    push_row(mk_br(br_blez, 32'd1, 32'd0, 1'b0, 16'h0004), '0, 1'b0);
    push_row(mk_br(br_bgtz, 32'd1, 32'd0, 1'b0, 16'h7fff), '0, 1'b0);
    push_row(mk_br(br_bgtz, 32'hffff_fffb, 32'd0, 1'b0, 16'h7fff), '0, 1'b0);
    push_row(with_rd(mk_br(br_beq, 32'd3, 32'd3, 1'b1, 16'h0008), 5'd3), '0, 1'b0);
    push_row(mk_bal(br_bltz, 32'hffff_fffb, 16'h0040), '0, 1'b0);
    push_row(mk_bal(br_bgez, 32'hffff_fffb, 16'h0040), '0, 1'b0);
    push_row(mk_jump(26'h012_3456, 1'b0), '0, 1'b1);
    push_row(mk_jump(26'h3ab_cdef, 1'b1), '0, 1'b1);
    push_row(mk_jreg(5'd24, 1'b0), '0, 1'b1);
    push_row(mk_jreg(5'd25, 1'b1), '0, 1'b1);
endtask

`endif

// File: verification/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        id_ex_t     id;
        wb_bypass_t wb;
        redirect_t  exp_redirect;
        ex_mem_t    exp_ex_mem;
    } row_t;

    logic       clk;
    logic       nrst;
    id_ex_t     id;
    wb_bypass_t wb;
    ex_mem_t    ex_mem;
    redirect_t  redirect;

    row_t        rows[$];
    logic [31:0] lcg_state = 32'h2d1bd0b1;
    int          cycles = 0;

    execute_stage i_execute_stage (
        .clk      (clk),
        .nrst     (nrst),
        .id       (id),
        .wb       (wb),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    `include "execute_stage_vectors.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic id_ex_t mk_empty();
        id_ex_t d;
        d = '0;
        d.valid = 1'b1;
        return d;
    endfunction

    function automatic id_ex_t mk_rr(alu_op_e op, logic [4:0] rs, logic [4:0] rt, logic [4:0] rd);
        id_ex_t d;
        d = mk_empty();
        d.alu_en = 1'b1;
        d.alu_op = op;
        d.rs_used = 1'b1;
        d.rs_addr = rs;
        d.rt_used = 1'b1;
        d.rt_addr = rt;
        return with_rd(d, rd);
    endfunction

    function automatic id_ex_t mk_ri(alu_op_e op, logic [4:0] rs, logic [4:0] rd,
                                     logic [15:0] imm);
        id_ex_t d;
        d = mk_empty();
        d.alu_en = 1'b1;
        d.alu_op = op;
        d.rs_used = 1'b1;
        d.rs_addr = rs;
        d.imm_en = 1'b1;
        d.imm = imm;
        return with_rd(d, rd);
    endfunction

    function automatic id_ex_t mk_sh(alu_op_e op, logic [4:0] rs, logic [4:0] rd,
                                     logic [4:0] sa);
        id_ex_t d;
        d = mk_empty();
        d.alu_en = 1'b1;
        d.alu_op = op;
        d.rs_used = 1'b1;
        d.rs_addr = rs;
        d.shamt_en = 1'b1;
        d.shamt = sa;
        return with_rd(d, rd);
    endfunction

    function automatic id_ex_t mk_mem(logic is_load, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
        id_ex_t d;
        d = mk_empty();
        d.rs_used = 1'b1;
        d.rs_addr = rs;
        d.rt_addr = rt;
        d.imm_en = 1'b1;
        d.imm = imm;
        d.load = is_load;
        d.store = !is_load;
        d.rt_used = !is_load; // a store reads rt, a load writes it
        d.rd_write = is_load;
        d.rd_addr = rt;
        return d;
    endfunction

    function automatic id_ex_t mk_br(branch_op_e op, logic [31:0] rs_val, logic [31:0] rt_val,
                                     logic two_reg, logic [15:0] imm);
        id_ex_t d;
        d = mk_empty();
        d.branch = 1'b1;
        d.branch_op = op;
        d.rs_used = 1'b1;
        d.rs_addr = 5'd24;
        d.rs_data = rs_val;
        d.rt_used = two_reg;
        d.rt_addr = 5'd25;
        d.rt_data = rt_val;
        d.imm_en = 1'b1;
        d.imm = imm;
        return d;
    endfunction

    function automatic id_ex_t mk_bal(branch_op_e op, logic [31:0] rs_val, logic [15:0] imm);
        id_ex_t d;
        d = with_link(mk_br(op, rs_val, 32'd0, 1'b0, imm));
        return d;
    endfunction

    function automatic id_ex_t mk_jump(logic [25:0] tgt, logic lnk);
        id_ex_t d;
        d = mk_empty();
        d.jump = 1'b1;
        d.target_en = 1'b1;
        d.target = tgt;
        return lnk ? with_link(d) : d;
    endfunction

    function automatic id_ex_t mk_jreg(logic [4:0] rs, logic lnk);
        id_ex_t d;
        d = mk_empty();
        d.jump = 1'b1;
        d.rs_used = 1'b1;
        d.rs_addr = rs;
        return lnk ? with_link(d) : d;
    endfunction

    // linking control transfers write pc plus 8 to r31 through addu
    function automatic id_ex_t with_link(id_ex_t d);
        d.link = 1'b1;
        d.alu_en = 1'b1;
        d.alu_op = alu_addu;
        return with_rd(d, 5'd31);
    endfunction

    function automatic id_ex_t with_rd(id_ex_t d, logic [4:0] rd);
        d.rd_write = 1'b1;
        d.rd_addr = rd;
        return d;
    endfunction

    function automatic id_ex_t without_valid(id_ex_t d);
        d.valid = 1'b0;
        return d;
    endfunction

    function automatic wb_bypass_t wb_write(logic [4:0] addr, logic [31:0] data);
        wb_bypass_t w;
        w.rd_write = 1'b1;
        w.rd_addr = addr;
        w.rd_data = data;
        return w;
    endfunction

    task automatic push_row(id_ex_t d, wb_bypass_t w, logic rnd);
        row_t r;
        d.pc = 32'h0040_0000 + 32'(rows.size()) * 32'd4;
        if (rnd) begin
            d.rs_data = lcg_next();
            d.rt_data = lcg_next();
        end
        r.id = d;
        r.wb = w;
        r.exp_redirect = '0;
        r.exp_ex_mem = '0;
        rows.push_back(r);
    endtask

    function automatic logic [31:0] forward(logic used, logic [4:0] addr, logic [31:0] reg_data,
                                            wb_bypass_t w, ex_mem_t prev);
        if (used && prev.rd_write && prev.rd_addr == addr) return prev.result;
        if (used && w.rd_write && w.rd_addr == addr) return w.rd_data;
        return reg_data;
    endfunction

    function automatic void ref_model(input id_ex_t d, input wb_bypass_t w, input ex_mem_t prev,
                                      output redirect_t r, output ex_mem_t e);
        logic [31:0] a;
        logic [31:0] rt_v;
        logic [31:0] imm_v;
        logic [31:0] b;
        logic [31:0] res;
        logic        sext;
        logic        cond;
        logic        rdw;
        a = forward(d.rs_used, d.rs_addr, d.rs_data, w, prev);
        rt_v = forward(d.rt_used, d.rt_addr, d.rt_data, w, prev);
        sext = d.load || d.store || d.branch ||
            (d.alu_en && d.alu_op inside {alu_add, alu_addu, alu_sub, alu_subu, alu_slt});
        if (d.imm_en) imm_v = sext ? {{16{d.imm[15]}}, d.imm} : {16'h0, d.imm};
        else if (d.shamt_en) imm_v = {27'h0, d.shamt};
        else imm_v = 32'h0;
        b = (!d.branch && (d.imm_en || d.shamt_en)) ? imm_v : rt_v;
        res = 32'h0;
        if (d.load || d.store) begin
            res = a + b;
        end else if (d.alu_en) begin
            case (d.alu_op)
                alu_add: res = a + b;
                alu_addu: res = d.link ? d.pc + 32'd8 : a + b;
                alu_sub, alu_subu: res = a - b;
                alu_and: res = a & b;
                alu_or: res = a | b;
                alu_xor: res = a ^ b;
                alu_nor: res = ~(a | b);
                alu_sll: res = a << b[4:0];
                alu_srl: res = a >> b[4:0];
                alu_sra: res = $unsigned($signed(a) >>> b[4:0]);
                alu_slt: res = {31'h0, $signed(a) < $signed(b)};
                alu_sltu: res = {31'h0, a < b};
                alu_lui: res = {b[15:0], 16'h0};
                default: res = 32'h0;
            endcase
        end
        case (d.branch_op)
            br_bltz: cond = $signed(a) < $signed(rt_v);
            br_bgez: cond = $signed(a) >= $signed(rt_v);
            br_beq: cond = a == rt_v;
            br_bne: cond = a != rt_v;
            br_blez: cond = $signed(a) <= $signed(rt_v);
            br_bgtz: cond = $signed(a) > $signed(rt_v);
            default: cond = 1'b0;
        endcase
        r.taken = d.valid && (d.jump || (d.branch && cond));
        r.target = 32'h0;
        rdw = d.rd_write;
        if (d.valid && (d.branch || d.jump)) begin
            if (d.target_en) r.target = {4'h0, d.target, 2'b00};
            else if (d.imm_en) r.target = d.pc + 32'd4 + (imm_v << 2);
            else if (d.rs_used) r.target = a;
            rdw = d.link && r.taken;
        end
        e = '0;
        if (d.valid && (d.alu_en || d.load || d.store || d.branch || d.jump || d.rd_write)) begin
            e.pc = d.pc;
            e.alu_en = d.alu_en;
            e.result = res;
            e.store_data = rt_v;
            e.rd_write = rdw;
            e.rd_addr = d.rd_addr;
            e.load = d.load;
            e.store = d.store;
        end
    endfunction

    task automatic check_value(logic [127:0] got, logic [127:0] exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > rows.size() + 20) begin
            $display("Something failed");
            $fatal(1, "timeout: the run took more cycles than the table allows");
        end
    end

    initial begin
        ex_mem_t prev;
        row_t    r;
        nrst = 1'b0;
        id = '0;
        wb = '0;
        build_rows();
        prev = '0;
        foreach (rows[i]) begin
            r = rows[i];
            ref_model(r.id, r.wb, prev, r.exp_redirect, r.exp_ex_mem);
            rows[i] = r;
            prev = r.exp_ex_mem;
        end
        id = rows[0].id; // a live instruction that reset has to keep out of ex_mem
        repeat (8) @(posedge clk);
        #5;
        nrst = 1'b1;
        id = '0;
        check_value(128'(ex_mem), 128'h0, "ex_mem after reset");
        foreach (rows[i]) begin
            @(posedge clk);
            #5;
            if (i > 0) begin
                check_value(128'(ex_mem), 128'(rows[i-1].exp_ex_mem),
                            $sformatf("ex_mem row %0d", i - 1));
            end
            id = rows[i].id;
            wb = rows[i].wb;
            #40;
            check_value(128'(redirect), 128'(rows[i].exp_redirect),
                        $sformatf("redirect row %0d", i));
        end
        @(posedge clk);
        #5;
        check_value(128'(ex_mem), 128'(rows[rows.size()-1].exp_ex_mem), "ex_mem last row");
        id = '0;
        wb = '0;
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: execute_stage.f
+incdir+verification
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/operand_select.sv
hw/alu.sv
hw/branch_unit.sv
hw/ex_mem_register.sv
hw/execute_stage.sv
verification/execute_stage_assertions.sv
verification/execute_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execute_stage_tb
FILELIST = execute_stage.f
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
